//--- files.f
+incdir+common
common/ui_pkg.sv
common/trace_pkg.sv
hw/replay_fifo.sv
hw/trace_replay/trace_replay.sv
hw/mem_model/ui_mem_model.sv
hw/replay_top.sv
dv/tb_replay.sv

//--- Makefile
# Verilator build of the trace replay testbench; run passes only when the pass line is printed

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module tb_replay \
		-f files.f -Mdir obj_dir -o sim_replay

run: compile
	@out="$$(./obj_dir/sim_replay)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- dv/tb_replay.sv
// Self-checking testbench for replay_top; loads trace batches and checks read data against a reference memory
`default_nettype none
`timescale 1ns/100ps

`include "replay_settings.svh"

module tb_replay;

    localparam int words_lp     = 2 ** `REPLAY_ADDR_WIDTH;
    localparam int batch_max_lp = `REPLAY_TRACE_DEPTH - 1;
    localparam int limit_lp     = 4000 + 100 * `REPLAY_MEM_LATENCY;

    typedef logic [`REPLAY_DATA_WIDTH-1:0]   word_t;
    typedef logic [`REPLAY_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`REPLAY_DATA_WIDTH/8-1:0] mask_t;

    logic                    clk;
    logic                    reset;
    trace_pkg::trace_entry_s trace;
    logic                    trace_v;
    logic                    trace_ready;
    word_t                   rd_data;
    logic                    rd_v;
    logic                    rd_ready;

    word_t                   ref_mem [words_lp];
    word_t                   staged_q [$];
    word_t                   expect_q [$];
    trace_pkg::trace_entry_s batch_q [$];

    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    int          reads_sent;
    int          beats_seen;
    bit          aborted;
    bit          long_stalls;

    replay_top dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .trace_i       (trace),
        .trace_v_i     (trace_v),
        .trace_ready_o (trace_ready),
        .rd_data_o     (rd_data),
        .rd_v_o        (rd_v),
        .rd_ready_i    (rd_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Mask bit set keeps the old byte
    function automatic word_t masked_write(input word_t old_word, input word_t new_word,
                                           input mask_t mask);
        word_t result;
        result = old_word;
        for (int b = 0; b < $bits(mask_t); b++) begin
            if (!mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic trace_pkg::trace_entry_s cmd_entry(input trace_pkg::trace_op_e op,
                                                          input addr_t addr);
        trace_pkg::trace_entry_s e;
        e = '0;
        e.op = op;
        e.payload.cmd.addr = addr;
        return e;
    endfunction

    function automatic trace_pkg::trace_entry_s data_entry(input word_t data, input mask_t mask);
        trace_pkg::trace_entry_s e;
        e = '0;
        e.op = trace_pkg::trace_wdata_last;
        e.payload.wdata.data = data;
        e.payload.wdata.mask = mask;
        return e;
    endfunction

    task automatic queue_write(input addr_t addr, input word_t data, input mask_t mask);
        batch_q.push_back(cmd_entry(trace_pkg::trace_wr_cmd, addr));
        batch_q.push_back(data_entry(data, mask));
        ref_mem[addr] = masked_write(ref_mem[addr], data, mask);
    endtask

    // Expected word follows trace order and sees earlier writes
    task automatic queue_read(input addr_t addr);
        batch_q.push_back(cmd_entry(trace_pkg::trace_rd_cmd, addr));
        staged_q.push_back(ref_mem[addr]);
    endtask

    task automatic queue_nop();
        batch_q.push_back(cmd_entry(trace_pkg::trace_nop, '0));
    endtask

    task automatic build_random_batch();
        addr_t addr;
        while (batch_q.size() < batch_max_lp - 3) begin
            if ($urandom_range(0, 3) == 0) begin
                queue_nop();
            end
            addr = addr_t'($urandom_range(0, 31));
            if ($urandom_range(0, 1) == 0) begin
                queue_write(addr, word_t'($urandom), mask_t'($urandom));
            end else begin
                queue_read(addr);
            end
        end
    endtask

    ////////////////////
    // Producer side
    ////////////////////

    task automatic send_entry(input trace_pkg::trace_entry_s e);
        int waited;
        waited = 0;
        while (!trace_ready && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > limit_lp) begin
                $display("Timeout: trace_ready_o stayed low while loading an entry");
                timeouts++;
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            trace   = e;
            trace_v = 1'b1;
            @(negedge clk);
            trace_v = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!trace_ready && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > limit_lp) begin
                $display("Timeout: trace_ready_o did not return high after the batch drained");
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_reads_done();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > limit_lp) begin
                $display("Timeout: %0d read beats never arrived", expect_q.size());
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic run_batch();
        trace_pkg::trace_entry_s e;
        while (batch_q.size() != 0) begin
            e = batch_q.pop_front();
            if (e.op == trace_pkg::trace_rd_cmd) begin
                reads_sent++;
            end
            send_entry(e);
        end
        // Beats become legal only once the execute marker goes out
        while (staged_q.size() != 0) begin
            expect_q.push_back(staged_q.pop_front());
        end
        send_entry(cmd_entry(trace_pkg::trace_exec, '0));
        if (!aborted) begin
            assert (!trace_ready) else begin
                $display("Engine still accepted entries right after the execute marker");
                protocol_errors++;
            end
        end
        wait_drained();
    endtask

    ////////////////////
    // Consumer side
    ////////////////////

    initial begin : consumer_proc
        int   stretch;
        logic level;
        stretch  = 0;
        level    = 1'b0;
        rd_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (stretch == 0) begin
                level = ~level;
                if (level) begin
                    stretch = $urandom_range(1, 6);
                end else if (long_stalls) begin
                    stretch = $urandom_range(20, 60);
                end else begin
                    stretch = $urandom_range(1, 3);
                end
            end
            stretch--;
            rd_ready = level;
        end
    end

    // Outputs are settled a quarter period after the falling edge
    initial begin : compare_proc
        word_t want;
        forever begin
            @(negedge clk);
            #1;
            if (!reset && rd_v) begin
                assert (expect_q.size() != 0) else begin
                    $display("Read beat appeared with no read outstanding");
                    protocol_errors++;
                end
                if (rd_ready) begin
                    beats_seen++;
                    if (expect_q.size() != 0) begin
                        want = expect_q.pop_front();
                        assert (rd_data == want) else begin
                            $display("[ERROR] rd_data_o expected %h actual %h", want, rd_data);
                            value_errors++;
                        end
                    end
                end
            end
        end
    end

    ////////////////////
    // Sequence
    ////////////////////

    initial begin : main_proc
        void'($urandom(32'h86798d10));
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        reads_sent      = 0;
        beats_seen      = 0;
        aborted         = 1'b0;
        long_stalls     = 1'b0;
        trace           = '0;
        trace_v         = 1'b0;
        reset           = 1'b1;
        for (int w = 0; w < words_lp; w++) begin
            ref_mem[w] = '0;
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!rd_v) else begin
            $display("Read valid was high right after reset");
            protocol_errors++;
        end

        // Full writes, read back, plus a word never written
        for (int i = 0; i < 4; i++) begin
            queue_write(addr_t'(16 + i), word_t'($urandom), '0);
        end
        for (int i = 0; i < 4; i++) begin
            queue_read(addr_t'(16 + i));
        end
        queue_read(addr_t'(128));
        run_batch();
        wait_reads_done();

        // Partial masks with no-ops in between
        queue_write(addr_t'(16), word_t'($urandom), 4'b0101);
        queue_nop();
        queue_write(addr_t'(17), word_t'($urandom), 4'b1111);
        queue_nop();
        queue_read(addr_t'(16));
        queue_read(addr_t'(17));
        queue_nop();
        queue_read(addr_t'(18));
        run_batch();
        wait_reads_done();

        // A batch of no-ops only
        repeat (5) queue_nop();
        run_batch();
        wait_reads_done();

        for (int n = 0; n < 10; n++) begin
            build_random_batch();
            run_batch();
        end
        wait_reads_done();

        long_stalls = 1'b1;
        for (int n = 0; n < 6; n++) begin
            build_random_batch();
            run_batch();
        end
        wait_reads_done();
        long_stalls = 1'b0;

        // Quiet window to catch stray beats
        repeat (4 * `REPLAY_MEM_LATENCY) @(negedge clk);
        assert (beats_seen == reads_sent) else begin
            $display("Received %0d read beats but sent %0d read entries", beats_seen, reads_sent);
            protocol_errors++;
        end

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/replay_top.sv
// Top level pairing the replay engine with the behavioral memory for stand-alone simulation
`default_nettype none
`timescale 1ns/100ps

`include "replay_settings.svh"

module replay_top (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire trace_pkg::trace_entry_s  trace_i,
    input  wire logic                     trace_v_i,
    output logic                          trace_ready_o,
    output logic [`REPLAY_DATA_WIDTH-1:0] rd_data_o,
    output logic                          rd_v_o,
    input  wire logic                     rd_ready_i
);

    ui_pkg::ui_cmd_s                app_cmd;
    ui_pkg::ui_wdata_s              app_wdata;
    logic                           app_rdy;
    logic                           app_wdf_rdy;
    logic                           rd_valid;
    logic [`REPLAY_DATA_WIDTH-1:0]  rd_data;

    trace_replay replay (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .trace_i        (trace_i),
        .trace_v_i      (trace_v_i),
        .trace_ready_o  (trace_ready_o),
        .rd_data_o      (rd_data_o),
        .rd_v_o         (rd_v_o),
        .rd_ready_i     (rd_ready_i),
        .app_cmd_o      (app_cmd),
        .app_rdy_i      (app_rdy),
        .app_wdata_o    (app_wdata),
        .app_wdf_rdy_i  (app_wdf_rdy),
        .app_rd_valid_i (rd_valid),
        .app_rd_data_i  (rd_data)
    );

    ui_mem_model mem (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .app_cmd_i     (app_cmd),
        .app_rdy_o     (app_rdy),
        .app_wdata_i   (app_wdata),
        .app_wdf_rdy_o (app_wdf_rdy),
        .rd_valid_o    (rd_valid),
        .rd_data_o     (rd_data)
    );

endmodule

`default_nettype wire

//--- hw/mem_model/ui_mem_model.sv
// Behavioral memory behind the user interface; stands in for the DDR controller in simulation
`default_nettype none
`timescale 1ns/100ps

`include "replay_settings.svh"

module ui_mem_model (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire ui_pkg::ui_cmd_s          app_cmd_i,
    output logic                          app_rdy_o,
    input  wire ui_pkg::ui_wdata_s        app_wdata_i,
    output logic                          app_wdf_rdy_o,
    output logic                          rd_valid_o,
    output logic [`REPLAY_DATA_WIDTH-1:0] rd_data_o
);

    localparam int words_lp = 2 ** `REPLAY_ADDR_WIDTH;
    localparam int bytes_lp = `REPLAY_DATA_WIDTH / 8;
    localparam int lat_lp   = `REPLAY_MEM_LATENCY;

    logic [`REPLAY_DATA_WIDTH-1:0] mem_r [words_lp];
    logic                          pend_v_r;
    logic [`REPLAY_ADDR_WIDTH-1:0] pend_addr_r;
    logic [lat_lp-1:0]             pipe_v_r;
    logic [`REPLAY_DATA_WIDTH-1:0] pipe_d_r [lat_lp];
    logic [15:0]                   lfsr_r;
    logic                          cmd_take;
    logic                          wdata_take;

    ////////////////////
    // Throttle
    ////////////////////

    // Taps for x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lfsr_r <= 16'hace1;
        end else begin
            lfsr_r <= {lfsr_r[14:0], lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10]};
        end
    end

    // Separate bit pairs throttle the two ready lines
    // No new command while a write waits for its data
    assign app_rdy_o     = ~pend_v_r & (lfsr_r[1:0] != 2'b00);
    assign app_wdf_rdy_o = (lfsr_r[3:2] != 2'b00);

    assign cmd_take   = app_cmd_i.en & app_rdy_o;
    assign wdata_take = app_wdata_i.wren & app_wdf_rdy_o;

    ////////////////////
    // Write path
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_v_r <= 1'b0;
        end else if (cmd_take && app_cmd_i.cmd == ui_pkg::app_cmd_write) begin
            pend_v_r <= 1'b1;
        end else if (wdata_take && app_wdata_i.last) begin
            pend_v_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_take && app_cmd_i.cmd == ui_pkg::app_cmd_write) begin
            pend_addr_r <= app_cmd_i.addr;
        end
    end

    // Array clears on reset so unwritten words read zero
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < words_lp; w++) begin
                mem_r[w] <= '0;
            end
        end else if (wdata_take) begin
            for (int b = 0; b < bytes_lp; b++) begin
                if (!app_wdata_i.mask[b]) begin
                    mem_r[pend_addr_r][8*b +: 8] <= app_wdata_i.data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // Read pipeline
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pipe_v_r <= '0;
        end else begin
            pipe_v_r <= {pipe_v_r[lat_lp-2:0],
                         cmd_take & (app_cmd_i.cmd == ui_pkg::app_cmd_read)};
        end
    end

    always_ff @(posedge clk_i) begin
        pipe_d_r[0] <= mem_r[app_cmd_i.addr];
        for (int i = 1; i < lat_lp; i++) begin
            pipe_d_r[i] <= pipe_d_r[i-1];
        end
    end

    assign rd_valid_o = pipe_v_r[lat_lp-1];
    assign rd_data_o  = pipe_d_r[lat_lp-1];

endmodule

`default_nettype wire

//--- hw/trace_replay/trace_replay.sv
// Fill/drain replay engine; stores trace entries until execute, then drives them onto the user interface
`default_nettype none
`timescale 1ns/100ps

`include "replay_settings.svh"

module trace_replay (
    input  wire logic                          clk_i,
    input  wire logic                          reset_i,

    // Producer side
    input  wire trace_pkg::trace_entry_s       trace_i,
    input  wire logic                          trace_v_i,
    output logic                               trace_ready_o,

    // Consumer side
    output logic [`REPLAY_DATA_WIDTH-1:0]      rd_data_o,
    output logic                               rd_v_o,
    input  wire logic                          rd_ready_i,

    // Controller user interface
    output ui_pkg::ui_cmd_s                    app_cmd_o,
    input  wire logic                          app_rdy_i,
    output ui_pkg::ui_wdata_s                  app_wdata_o,
    input  wire logic                          app_wdf_rdy_i,
    input  wire logic                          app_rd_valid_i,
    input  wire logic [`REPLAY_DATA_WIDTH-1:0] app_rd_data_i
);

    localparam int cnt_w_lp = $clog2(`REPLAY_READ_DEPTH + 1);

    typedef enum logic {
        st_fill,
        st_drain
    } state_e;

    state_e                   state_r;
    state_e                   state_n;
    logic                     is_exec_in;
    logic                     store_v_li;
    logic                     store_ready_lo;
    trace_pkg::trace_entry_s  head;
    logic                     head_v;
    logic                     head_yumi;
    logic [cnt_w_lp-1:0]      rd_held;
    logic [cnt_w_lp-1:0]      inflight_r;
    logic [cnt_w_lp-1:0]      credit_free;
    logic                     read_avail;
    logic                     is_write;
    logic                     is_read;
    logic                     is_wdata;
    logic                     is_wlast;
    logic                     is_nop;
    logic                     issue_read;

    ////////////////////
    // Trace store
    ////////////////////

    // Execute marker only switches phase, it is not kept
    assign is_exec_in = (trace_i.op == trace_pkg::trace_exec);
    assign store_v_li = (state_r == st_fill) & trace_v_i & ~is_exec_in;
    assign trace_ready_o = (state_r == st_fill) & store_ready_lo;

    replay_fifo #(
        .payload_t (trace_pkg::trace_entry_s),
        .depth_p   (`REPLAY_TRACE_DEPTH)
    ) trace_store (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (trace_i),
        .v_i     (store_v_li),
        .ready_o (store_ready_lo),
        .data_o  (head),
        .v_o     (head_v),
        .yumi_i  (head_yumi),
        .count_o ()
    );

    ////////////////////
    // Read return path
    ////////////////////

    replay_fifo #(
        .payload_t (logic [`REPLAY_DATA_WIDTH-1:0]),
        .depth_p   (`REPLAY_READ_DEPTH)
    ) read_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (app_rd_data_i),
        .v_i     (app_rd_valid_i),
        .ready_o (),
        .data_o  (rd_data_o),
        .v_o     (rd_v_o),
        .yumi_i  (rd_v_o & rd_ready_i),
        .count_o (rd_held)
    );

    // Room left once held beats and outstanding reads are counted
    assign credit_free = cnt_w_lp'(`REPLAY_READ_DEPTH) - rd_held - inflight_r;
    assign read_avail  = (credit_free >= cnt_w_lp'(`REPLAY_BURST_LEN));
    assign issue_read  = app_cmd_o.en & app_rdy_i & is_read;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            inflight_r <= '0;
        end else begin
            inflight_r <= inflight_r
                        + (issue_read ? cnt_w_lp'(`REPLAY_BURST_LEN) : '0)
                        - (app_rd_valid_i ? cnt_w_lp'(1) : '0);
        end
    end

    ////////////////////
    // Drain control
    ////////////////////

    assign is_write = (head.op == trace_pkg::trace_wr_cmd);
    assign is_read  = (head.op == trace_pkg::trace_rd_cmd);
    assign is_wlast = (head.op == trace_pkg::trace_wdata_last);
    assign is_wdata = (head.op == trace_pkg::trace_wdata) | is_wlast;
    assign is_nop   = (head.op == trace_pkg::trace_nop);

    always_comb begin
        state_n = state_r;

        app_cmd_o.cmd  = is_read ? ui_pkg::app_cmd_read : ui_pkg::app_cmd_write;
        app_cmd_o.addr = head.payload.cmd.addr;
        app_cmd_o.en   = 1'b0;

        app_wdata_o.data = head.payload.wdata.data;
        app_wdata_o.mask = head.payload.wdata.mask;
        app_wdata_o.wren = 1'b0;
        app_wdata_o.last = 1'b0;

        head_yumi = 1'b0;

        unique case (state_r)
            st_fill: begin
                if (trace_v_i & is_exec_in) begin
                    state_n = st_drain;
                end
            end
            st_drain: begin
                app_cmd_o.en     = head_v & (is_write | (is_read & read_avail));
                app_wdata_o.wren = head_v & is_wdata;
                app_wdata_o.last = head_v & is_wlast;

                // At most one entry leaves the store per cycle
                head_yumi = head_v & ((app_cmd_o.en & app_rdy_i)
                                    | (app_wdata_o.wren & app_wdf_rdy_i)
                                    | is_nop);

                if (!head_v) begin
                    state_n = st_fill;
                end
            end
            default: state_n = st_fill;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= st_fill;
        end else begin
            state_r <= state_n;
        end
    end

endmodule

`default_nettype wire

//--- hw/replay_fifo.sv
// Small synchronous FIFO with a typed payload; used for the trace store and the read buffer
`default_nettype none
`timescale 1ns/100ps

module replay_fifo #(
    parameter type payload_t = logic,
    parameter int  depth_p   = 4,
    localparam int cnt_w_lp  = $clog2(depth_p + 1)
) (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire payload_t            data_i,
    input  wire logic                v_i,
    output logic                     ready_o,
    output payload_t                 data_o,
    output logic                     v_o,
    input  wire logic                yumi_i,
    output logic [cnt_w_lp-1:0]      count_o
);

    localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
    localparam logic [ptr_w_lp-1:0] last_ptr_lp = ptr_w_lp'(depth_p - 1);

    payload_t              mem_r [depth_p];
    logic [ptr_w_lp-1:0]   wr_ptr_r;
    logic [ptr_w_lp-1:0]   rd_ptr_r;
    logic [cnt_w_lp-1:0]   count_r;
    logic                  do_wr;
    logic                  do_rd;

    // Full check ignores a same-cycle pop
    assign ready_o = (count_r != cnt_w_lp'(depth_p));
    assign v_o     = (count_r != '0);
    assign data_o  = mem_r[rd_ptr_r];
    assign count_o = count_r;

    assign do_wr = v_i & ready_o;
    assign do_rd = yumi_i & v_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
            end
            unique case ({do_wr, do_rd})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_r[wr_ptr_r] <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- common/trace_pkg.sv
// Trace entry format loaded by the producer into the replay engine
`default_nettype none

`include "replay_settings.svh"

package trace_pkg;

    typedef enum logic [2:0] {
        trace_wr_cmd     = 3'b000,
        trace_rd_cmd     = 3'b001,
        trace_wdata      = 3'b010,
        trace_wdata_last = 3'b011,
        trace_nop        = 3'b100,
        trace_exec       = 3'b101
    } trace_op_e;

    localparam int payload_width_lp = `REPLAY_DATA_WIDTH + `REPLAY_DATA_WIDTH / 8;

    // Command view, address in the low bits
    typedef struct packed {
        logic [payload_width_lp-`REPLAY_ADDR_WIDTH-1:0] pad;
        logic [`REPLAY_ADDR_WIDTH-1:0]                  addr;
    } trace_cmd_s;

    typedef struct packed {
        logic [`REPLAY_DATA_WIDTH-1:0]   data;
        logic [`REPLAY_DATA_WIDTH/8-1:0] mask;
    } trace_data_s;

    typedef union packed {
        trace_cmd_s  cmd;
        trace_data_s wdata;
    } trace_payload_u;

    typedef struct packed {
        trace_op_e      op;
        trace_payload_u payload;
    } trace_entry_s;

endpackage

`default_nettype wire

//--- common/ui_pkg.sv
// Memory-controller user-interface types shared by the replay engine, the memory model and the top
`default_nettype none

`include "replay_settings.svh"

package ui_pkg;

    // Command encoding as seen on a DDR controller user interface
    typedef enum logic [2:0] {
        app_cmd_write = 3'b000,
        app_cmd_read  = 3'b001
    } app_cmd_e;

    typedef struct packed {
        app_cmd_e                      cmd;
        logic [`REPLAY_ADDR_WIDTH-1:0] addr;
        logic                          en;
    } ui_cmd_s;

    // Mask bit set means that byte is left untouched
    typedef struct packed {
        logic [`REPLAY_DATA_WIDTH-1:0]   data;
        logic [`REPLAY_DATA_WIDTH/8-1:0] mask;
        logic                            wren;
        logic                            last;
    } ui_wdata_s;

endpackage

`default_nettype wire

//--- common/replay_settings.svh
// Build-wide sizing macros for the trace replay subsystem; include wherever widths or depths are needed
`ifndef REPLAY_SETTINGS_SVH
`define REPLAY_SETTINGS_SVH

// Data beat width in bits
`define REPLAY_DATA_WIDTH 32

// Word address width, 256 words in the model
`define REPLAY_ADDR_WIDTH 8

// Beats returned per read command
`define REPLAY_BURST_LEN 1

// Buffer depths inside the engine
`define REPLAY_TRACE_DEPTH 16
`define REPLAY_READ_DEPTH 4

// Cycles from a taken read command to its data
`define REPLAY_MEM_LATENCY 3

`endif
